// ==== hw/phy_csr_pkg.sv ====
`default_nettype none

package phy_csr_pkg;

	// the host port moves one 32-bit word per request
	localparam int CSR_ADDR_WIDTH = 8;
	localparam int CSR_DATA_WIDTH = 32;
	localparam int CSR_BE_WIDTH = 4;

	// the version word carries the major number in the upper half and the minor in the lower half
	localparam logic [15:0] CSR_IP_VERSION = 16'd211;
	localparam logic [15:0] CSR_IP_SUBVERSION = 16'd4;

	// fixed pattern that lets the host confirm it is talking to this block
	localparam logic [31:0] CSR_MAGIC = 32'hdeadbeef;

	// word addresses of the register map
	// addresses that are not listed here read back as zero
	localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MAGIC = 8'd1;
	localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_VERSION = 8'd2;
	localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_STATUS = 8'd4;
	localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_FOM = 8'd5;
	localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_FAIL_LOC = 8'd6;
	localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_RESERVED = 8'd7;
	localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MR3 = 8'd8;

	// status word flags sit in the top byte
	localparam int STATUS_CAL_SUCCESS_BIT = 24;
	localparam int STATUS_CAL_FAIL_BIT = 25;
	localparam int STATUS_PLL_LOCKED_BIT = 26;

	// low bit of each byte field in the figure of merit word
	localparam int FOM_IN_LSB = 0;
	localparam int FOM_OUT_LSB = 16;

	// low bit of each byte field in the fail location word
	localparam int FAIL_STAGE_LSB = 0;
	localparam int FAIL_SUBSTAGE_LSB = 8;
	localparam int FAIL_GROUP_LSB = 16;

	// the sequencer walks groups fastest, then substages, then stages
	localparam int CAL_STAGES = 3;
	localparam int CAL_SUBSTAGES = 2;
	localparam int CAL_GROUPS = 4;

	// consecutive synchronized high samples needed before lock is believed
	localparam int LOCK_FILTER_CYCLES = 8;

	// output drive strength code as programmed into MR3
	localparam logic [3:0] MR3_DRIVE_STRENGTH = 4'd2;

endpackage

`default_nettype wire

// ==== hw/pll_lock_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pll_lock_filter (
	input logic clk,
	input logic reset_n,
	input logic pll_locked,
	output logic pll_locked_stable
);

	import phy_csr_pkg::*;

	// the counter only has to reach LOCK_FILTER_CYCLES-1, so a single bit covers the smallest case
	localparam int CNT_W = (LOCK_FILTER_CYCLES > 2) ? $clog2(LOCK_FILTER_CYCLES) : 1;

	// two stage synchronizer, sync_q[1] is the level the rest of the logic trusts
	logic [1:0] sync_q;
	logic [CNT_W-1:0] cnt_q;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sync_q <= '0;
			cnt_q <= '0;
			pll_locked_stable <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], pll_locked};
			// a single low sample throws away all the history gathered so far
			if (!sync_q[1]) begin
				cnt_q <= '0;
				pll_locked_stable <= 1'b0;
			end else if (cnt_q == CNT_W'(LOCK_FILTER_CYCLES - 1)) begin
				// the count saturates here and lock is then reported until the level drops
				pll_locked_stable <= 1'b1;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// lock can only be declared on the heels of a synchronized high sample
	a_rise_needs_sync_high: assert property (
		@(posedge clk) disable iff (!reset_n)
		$rose(pll_locked_stable) |-> $past(sync_q[1])
	);

endmodule

`default_nettype wire

// ==== hw/cal_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cal_sequencer (
	input logic clk,
	input logic reset_n,
	input logic pll_locked_stable,
	input logic cal_start,
	input logic step_ok,
	output logic cal_busy,
	output logic cal_success,
	output logic cal_fail,
	output logic [7:0] fom_in,
	output logic [7:0] fom_out,
	output logic [7:0] fail_stage,
	output logic [7:0] fail_substage,
	output logic [7:0] fail_group
);

	import phy_csr_pkg::*;

	// counter widths, kept at one bit or more so a geometry of one still builds
	localparam int STAGE_W = (CAL_STAGES > 1) ? $clog2(CAL_STAGES) : 1;
	localparam int SUB_W = (CAL_SUBSTAGES > 1) ? $clog2(CAL_SUBSTAGES) : 1;
	localparam int GRP_W = (CAL_GROUPS > 1) ? $clog2(CAL_GROUPS) : 1;

	logic [STAGE_W-1:0] stage_q;
	logic [SUB_W-1:0] sub_q;
	logic [GRP_W-1:0] grp_q;
	logic fail_seen_q;
	logic grp_last;
	logic sub_last;
	logic last_step;
	logic any_fail;

	assign grp_last = (grp_q == GRP_W'(CAL_GROUPS - 1));
	assign sub_last = (sub_q == SUB_W'(CAL_SUBSTAGES - 1));
	// the last step is the final group of the final substage of the final stage
	assign last_step = grp_last && sub_last && (stage_q == STAGE_W'(CAL_STAGES - 1));
	// includes the step being judged on this edge, which matters for the last one
	assign any_fail = fail_seen_q || !step_ok;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			cal_busy <= 1'b0;
			cal_success <= 1'b0;
			cal_fail <= 1'b0;
			fom_in <= '0;
			fom_out <= '0;
			fail_stage <= '0;
			fail_substage <= '0;
			fail_group <= '0;
			stage_q <= '0;
			sub_q <= '0;
			grp_q <= '0;
			fail_seen_q <= 1'b0;
		end else if (!pll_locked_stable || (!cal_busy && cal_start)) begin
			// losing lock and accepting a start both wipe every result
			// only the accepted start leaves the sequencer busy
			cal_busy <= pll_locked_stable;
			cal_success <= 1'b0;
			cal_fail <= 1'b0;
			fom_in <= '0;
			fom_out <= '0;
			fail_stage <= '0;
			fail_substage <= '0;
			fail_group <= '0;
			stage_q <= '0;
			sub_q <= '0;
			grp_q <= '0;
			fail_seen_q <= 1'b0;
		end else if (cal_busy) begin
			// stage 0 is the read side and stage 1 the write side
			// passes in stage 2 only count toward the overall verdict
			if (step_ok) begin
				if (stage_q == STAGE_W'(0)) begin
					fom_in <= fom_in + 8'd1;
				end else if (stage_q == STAGE_W'(1)) begin
					fom_out <= fom_out + 8'd1;
				end
			end else if (!fail_seen_q) begin
				// only the first failing step is kept, later failures leave it alone
				fail_seen_q <= 1'b1;
				fail_stage <= 8'(stage_q);
				fail_substage <= 8'(sub_q);
				fail_group <= 8'(grp_q);
			end
			if (last_step) begin
				cal_busy <= 1'b0;
				cal_success <= !any_fail;
				cal_fail <= any_fail;
			end else if (grp_last) begin
				grp_q <= '0;
				if (sub_last) begin
					sub_q <= '0;
					stage_q <= stage_q + 1'b1;
				end else begin
					sub_q <= sub_q + 1'b1;
				end
			end else begin
				grp_q <= grp_q + 1'b1;
			end
		end
	end

	// the verdict is one or the other, never both
	a_verdict_exclusive: assert property (
		@(posedge clk) disable iff (!reset_n)
		!(cal_success && cal_fail)
	);

	// a drop in lock is seen by the sequencer one edge later, after which it must be idle
	a_idle_without_lock: assert property (
		@(posedge clk) disable iff (!reset_n)
		!pll_locked_stable |=> !cal_busy
	);

endmodule

`default_nettype wire

// ==== hw/phy_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_csr (
	input logic clk,
	input logic reset_n,
	input logic [phy_csr_pkg::CSR_ADDR_WIDTH-1:0] csr_addr,
	input logic [phy_csr_pkg::CSR_BE_WIDTH-1:0] csr_be,
	input logic csr_write_req,
	input logic [phy_csr_pkg::CSR_DATA_WIDTH-1:0] csr_wdata,
	input logic csr_read_req,
	output logic [phy_csr_pkg::CSR_DATA_WIDTH-1:0] csr_rdata,
	output logic csr_rdata_valid,
	output logic csr_waitrequest,
	input logic pll_locked_stable,
	input logic cal_success,
	input logic cal_fail,
	input logic [7:0] fom_in,
	input logic [7:0] fom_out,
	input logic [7:0] fail_stage,
	input logic [7:0] fail_substage,
	input logic [7:0] fail_group
);

	import phy_csr_pkg::*;

	// first request stage, sampled straight off the port
	logic read_q;
	logic write_q;
	logic [CSR_ADDR_WIDTH-1:0] addr_q;
	logic [CSR_BE_WIDTH-1:0] be_q;
	logic [CSR_DATA_WIDTH-1:0] wdata_q;
	// second request stage, lines up with the status snapshot
	logic read_d2_q;
	logic [CSR_ADDR_WIDTH-1:0] addr_d2_q;
	// snapshot copies of the live status words
	logic [CSR_DATA_WIDTH-1:0] status_word_q;
	logic [CSR_DATA_WIDTH-1:0] fom_word_q;
	logic [CSR_DATA_WIDTH-1:0] fail_word_q;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			read_q <= 1'b0;
			write_q <= 1'b0;
			read_d2_q <= 1'b0;
		end else begin
			read_q <= csr_read_req;
			// a write is taken in and then dropped since nothing in the map is writable
			write_q <= csr_write_req;
			read_d2_q <= read_q;
		end
	end

	// address and write payload simply follow the port every cycle
	always_ff @(posedge clk) begin
		addr_q <= csr_addr;
		be_q <= csr_be;
		wdata_q <= csr_wdata;
		addr_d2_q <= addr_q;
	end

	// status is resampled every cycle, so a read sees the inputs one edge after its request
	always_ff @(posedge clk) begin
		status_word_q <= '0;
		status_word_q[STATUS_CAL_SUCCESS_BIT] <= cal_success;
		status_word_q[STATUS_CAL_FAIL_BIT] <= cal_fail;
		status_word_q[STATUS_PLL_LOCKED_BIT] <= pll_locked_stable;
		fom_word_q <= '0;
		fom_word_q[FOM_IN_LSB +: 8] <= fom_in;
		fom_word_q[FOM_OUT_LSB +: 8] <= fom_out;
		fail_word_q <= '0;
		fail_word_q[FAIL_STAGE_LSB +: 8] <= fail_stage;
		fail_word_q[FAIL_SUBSTAGE_LSB +: 8] <= fail_substage;
		fail_word_q[FAIL_GROUP_LSB +: 8] <= fail_group;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			csr_rdata <= '0;
			csr_rdata_valid <= 1'b0;
			csr_waitrequest <= 1'b1;
		end else begin
			// the port is ready from the first edge out of reset and never stalls again
			csr_waitrequest <= 1'b0;
			csr_rdata_valid <= read_d2_q;
			if (read_d2_q) begin
				case (addr_d2_q)
					CSR_ADDR_MAGIC: csr_rdata <= CSR_MAGIC;
					CSR_ADDR_VERSION: csr_rdata <= {CSR_IP_VERSION, CSR_IP_SUBVERSION};
					CSR_ADDR_STATUS: csr_rdata <= status_word_q;
					CSR_ADDR_FOM: csr_rdata <= fom_word_q;
					CSR_ADDR_FAIL_LOC: csr_rdata <= fail_word_q;
					CSR_ADDR_RESERVED: csr_rdata <= '0;
					CSR_ADDR_MR3: csr_rdata <= CSR_DATA_WIDTH'(MR3_DRIVE_STRENGTH);
					default: csr_rdata <= '0;
				endcase
			end
		end
	end

	// valid is sampled three clocks after the request, i.e. after the second edge following it
	a_valid_follows_read: assert property (
		@(posedge clk) disable iff (!reset_n)
		csr_rdata_valid |-> $past(csr_read_req, 3)
	);

	// write payload must be driven whenever the host raises a write
	a_write_payload_known: assert property (
		@(posedge clk) disable iff (!reset_n)
		write_q |-> !$isunknown({addr_q, be_q, wdata_q})
	);

endmodule

`default_nettype wire

// ==== hw/phy_status_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_status_top (
	input logic clk,
	input logic reset_n,
	input logic [phy_csr_pkg::CSR_ADDR_WIDTH-1:0] csr_addr,
	input logic [phy_csr_pkg::CSR_BE_WIDTH-1:0] csr_be,
	input logic csr_write_req,
	input logic [phy_csr_pkg::CSR_DATA_WIDTH-1:0] csr_wdata,
	input logic csr_read_req,
	output logic [phy_csr_pkg::CSR_DATA_WIDTH-1:0] csr_rdata,
	output logic csr_rdata_valid,
	output logic csr_waitrequest,
	input logic pll_locked,
	input logic cal_start,
	input logic step_ok,
	output logic cal_busy
);

	// filtered lock feeds both the sequencer and the status word
	logic pll_locked_stable;
	logic cal_success;
	logic cal_fail;
	logic [7:0] fom_in;
	logic [7:0] fom_out;
	logic [7:0] fail_stage;
	logic [7:0] fail_substage;
	logic [7:0] fail_group;

	pll_lock_filter lock_filter0 (
		.clk(clk),
		.reset_n(reset_n),
		.pll_locked(pll_locked),
		.pll_locked_stable(pll_locked_stable)
	);

	cal_sequencer cal_seq0 (
		.clk(clk),
		.reset_n(reset_n),
		.pll_locked_stable(pll_locked_stable),
		.cal_start(cal_start),
		.step_ok(step_ok),
		.cal_busy(cal_busy),
		.cal_success(cal_success),
		.cal_fail(cal_fail),
		.fom_in(fom_in),
		.fom_out(fom_out),
		.fail_stage(fail_stage),
		.fail_substage(fail_substage),
		.fail_group(fail_group)
	);

	phy_csr csr0 (
		.clk(clk),
		.reset_n(reset_n),
		.csr_addr(csr_addr),
		.csr_be(csr_be),
		.csr_write_req(csr_write_req),
		.csr_wdata(csr_wdata),
		.csr_read_req(csr_read_req),
		.csr_rdata(csr_rdata),
		.csr_rdata_valid(csr_rdata_valid),
		.csr_waitrequest(csr_waitrequest),
		.pll_locked_stable(pll_locked_stable),
		.cal_success(cal_success),
		.cal_fail(cal_fail),
		.fom_in(fom_in),
		.fom_out(fom_out),
		.fail_stage(fail_stage),
		.fail_substage(fail_substage),
		.fail_group(fail_group)
	);

endmodule

`default_nettype wire

// ==== tests/tb_phy_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_phy_status;

	import phy_csr_pkg::*;

	localparam int CAL_STEPS = CAL_STAGES * CAL_SUBSTAGES * CAL_GROUPS;
	localparam int STEPS_PER_STAGE = CAL_SUBSTAGES * CAL_GROUPS;
	// six tests of at most about 400 cycles each, plus margin for reset and draining
	localparam int TEST_COUNT = 6;
	localparam int MAX_TEST_CYCLES = 400;
	localparam int TIMEOUT_CYCLES = TEST_COUNT * MAX_TEST_CYCLES + 1600;

	logic clk = 1'b0;
	logic reset_n;
	logic [CSR_ADDR_WIDTH-1:0] csr_addr;
	logic [CSR_BE_WIDTH-1:0] csr_be;
	logic csr_write_req;
	logic [CSR_DATA_WIDTH-1:0] csr_wdata;
	logic csr_read_req;
	logic [CSR_DATA_WIDTH-1:0] csr_rdata;
	logic csr_rdata_valid;
	logic csr_waitrequest;
	logic pll_locked;
	logic cal_start;
	logic step_ok;
	logic cal_busy;

	// outstanding reads, the expected word and the cycle its valid is due in
	logic [CSR_DATA_WIDTH-1:0] exp_q[$];
	int due_q[$];
	int cyc = 0;
	int errors = 0;
	int err_base = 0;
	int ok_tests = 0;
	int bad_tests = 0;
	string cur_test;
	logic [31:0] rng = 32'h9602;
	// model of what the DUT should be holding right now
	logic ref_locked;
	logic ref_done;
	logic [CAL_STEPS-1:0] ref_mask;
	logic [CSR_ADDR_WIDTH-1:0] mapped_addrs [0:6];

	phy_status_top dut0 (
		.clk(clk),
		.reset_n(reset_n),
		.csr_addr(csr_addr),
		.csr_be(csr_be),
		.csr_write_req(csr_write_req),
		.csr_wdata(csr_wdata),
		.csr_read_req(csr_read_req),
		.csr_rdata(csr_rdata),
		.csr_rdata_valid(csr_rdata_valid),
		.csr_waitrequest(csr_waitrequest),
		.pll_locked(pll_locked),
		.cal_start(cal_start),
		.step_ok(step_ok),
		.cal_busy(cal_busy)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected word at an address, given the step mask of the last finished calibration
	function automatic logic [31:0] ref_read(input logic [7:0] addr,
			input logic [CAL_STEPS-1:0] mask, input logic locked, input logic done);
		logic [31:0] v;
		int first;
		int fin;
		int fout;
		v = '0;
		first = -1;
		fin = 0;
		fout = 0;
		// without a finished run every count and location is zero
		for (int k = 0; k < CAL_STEPS; k++) begin
			if (done && mask[k]) begin
				if (k / STEPS_PER_STAGE == 0) fin++;
				else if (k / STEPS_PER_STAGE == 1) fout++;
			end else if (done && first < 0) begin
				first = k;
			end
		end
		case (addr)
			CSR_ADDR_MAGIC: v = CSR_MAGIC;
			// major number in the upper half, minor number in the lower half
			CSR_ADDR_VERSION: v = (32'(CSR_IP_VERSION) << 16) | 32'(CSR_IP_SUBVERSION);
			CSR_ADDR_STATUS: begin
				v[STATUS_PLL_LOCKED_BIT] = locked;
				v[STATUS_CAL_SUCCESS_BIT] = done && (first < 0);
				v[STATUS_CAL_FAIL_BIT] = done && (first >= 0);
			end
			CSR_ADDR_FOM: begin
				v[FOM_IN_LSB +: 8] = 8'(fin);
				v[FOM_OUT_LSB +: 8] = 8'(fout);
			end
			CSR_ADDR_FAIL_LOC: begin
				// steps go group fastest, then substage, then stage
				if (first >= 0) begin
					v[FAIL_STAGE_LSB +: 8] = 8'(first / STEPS_PER_STAGE);
					v[FAIL_SUBSTAGE_LSB +: 8] = 8'((first / CAL_GROUPS) % CAL_SUBSTAGES);
					v[FAIL_GROUP_LSB +: 8] = 8'(first % CAL_GROUPS);
				end
			end
			CSR_ADDR_MR3: v = 32'(MR3_DRIVE_STRENGTH);
			default: v = '0;
		endcase
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, got %h (cycle %0d)", name, exp, act, cyc);
			errors++;
		end
	endtask

	task automatic flag_failure(input string what);
		$display("%s (cycle %0d)", what, cyc);
		errors++;
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_base = errors;
	endtask

	task automatic end_test();
		if (errors == err_base) begin
			ok_tests++;
			$display("%s: ok", cur_test);
		end else begin
			bad_tests++;
			$display("%s: %0d errors", cur_test, errors - err_base);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	// the request is sampled at the next edge, valid is due two edges after that
	task automatic issue_read(input logic [7:0] addr);
		exp_q.push_back(ref_read(addr, ref_mask, ref_locked, ref_done));
		due_q.push_back(cyc + 3);
		csr_read_req = 1'b1;
		csr_addr = addr;
		@(posedge clk);
		#2;
		csr_read_req = 1'b0;
	endtask

	task automatic drain_reads();
		while (due_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic issue_write(input logic [7:0] addr, input logic [31:0] data);
		csr_write_req = 1'b1;
		csr_addr = addr;
		csr_be = '1;
		csr_wdata = data;
		@(posedge clk);
		#2;
		csr_write_req = 1'b0;
	endtask

	// step k is presented in the k-th busy cycle, a negative drop_at keeps lock throughout
	task automatic run_calibration(input logic [CAL_STEPS-1:0] mask, input int drop_at);
		int k;
		cal_start = 1'b1;
		@(posedge clk);
		#2;
		cal_start = 1'b0;
		check_value("cal_busy", 32'd1, 32'(cal_busy));
		k = 0;
		step_ok = mask[0];
		while (cal_busy) begin
			@(posedge clk);
			#2;
			k++;
			step_ok = (k < CAL_STEPS) ? mask[k] : 1'b1;
			if (k == drop_at) pll_locked = 1'b0;
		end
		step_ok = 1'b0;
		if (drop_at < 0) check_value("cal busy cycles", 32'(CAL_STEPS), 32'(k));
	endtask

	// cycle count also bounds the run
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles in %s", cyc, cur_test);
			$display("test failed");
			$finish;
		end
	end

	// every valid must line up with the oldest outstanding read, on its due cycle
	always @(negedge clk) begin
		if (reset_n) begin
			if (due_q.size() != 0 && due_q[0] < cyc) begin
				flag_failure($sformatf("no read response arrived in cycle %0d", due_q[0]));
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
			end
			if (csr_rdata_valid) begin
				if (due_q.size() == 0) begin
					flag_failure("read data valid with no read outstanding");
				end else begin
					if (due_q[0] != cyc) begin
						flag_failure($sformatf("read response due in cycle %0d came early",
							due_q[0]));
					end
					check_value("csr_rdata", exp_q.pop_front(), csr_rdata);
					void'(due_q.pop_front());
				end
			end
		end
	end

	initial begin
		logic [CAL_STEPS-1:0] mask;
		logic [31:0] r1;
		reset_n = 1'b0;
		csr_addr = '0;
		csr_be = '0;
		csr_write_req = 1'b0;
		csr_wdata = '0;
		csr_read_req = 1'b0;
		pll_locked = 1'b0;
		cal_start = 1'b0;
		step_ok = 1'b0;
		ref_locked = 1'b0;
		ref_done = 1'b0;
		ref_mask = '0;
		mapped_addrs[0] = CSR_ADDR_MAGIC;
		mapped_addrs[1] = CSR_ADDR_VERSION;
		mapped_addrs[2] = CSR_ADDR_STATUS;
		mapped_addrs[3] = CSR_ADDR_FOM;
		mapped_addrs[4] = CSR_ADDR_FAIL_LOC;
		mapped_addrs[5] = CSR_ADDR_RESERVED;
		mapped_addrs[6] = CSR_ADDR_MR3;
		repeat (16) @(posedge clk);
		#2;

		begin_test("reset values and read latency");
		check_value("csr_waitrequest", 32'd1, 32'(csr_waitrequest));
		reset_n = 1'b1;
		idle_cycles(1);
		check_value("csr_waitrequest", 32'd0, 32'(csr_waitrequest));
		// these go back to back, so valid must stay high over consecutive cycles
		issue_read(8'd1);
		issue_read(8'd2);
		issue_read(8'd7);
		issue_read(8'd8);
		issue_read(8'd0);
		issue_read(8'd3);
		issue_read(8'd9);
		issue_read(8'd255);
		drain_reads();
		end_test();

		begin_test("lock filter");
		// one cycle short of the filter length must not count as lock
		pll_locked = 1'b1;
		idle_cycles(LOCK_FILTER_CYCLES - 1);
		pll_locked = 1'b0;
		// the status word is read every cycle so even a one cycle flicker of lock would show
		for (int i = 0; i < 8; i++) issue_read(CSR_ADDR_STATUS);
		drain_reads();
		pll_locked = 1'b1;
		idle_cycles(LOCK_FILTER_CYCLES + 12);
		ref_locked = 1'b1;
		issue_read(CSR_ADDR_STATUS);
		drain_reads();
		end_test();

		begin_test("calibration success");
		run_calibration('1, -1);
		ref_mask = '1;
		ref_done = 1'b1;
		issue_read(CSR_ADDR_STATUS);
		issue_read(CSR_ADDR_FOM);
		issue_read(CSR_ADDR_FAIL_LOC);
		drain_reads();
		end_test();

		begin_test("calibration failures");
		for (int i = 0; i < 4; i++) begin
			// or of two draws keeps zeros sparse so failures land at varied steps
			rng = lcg_next(rng);
			r1 = rng;
			rng = lcg_next(rng);
			mask = r1[31:8] | rng[31:8];
			if (&mask) mask[0] = 1'b0;
			run_calibration(mask, -1);
			ref_mask = mask;
			issue_read(CSR_ADDR_STATUS);
			issue_read(CSR_ADDR_FOM);
			issue_read(CSR_ADDR_FAIL_LOC);
			rng = lcg_next(rng);
			issue_read(rng[23:16] % 8'd10);
			drain_reads();
		end
		end_test();

		begin_test("lock loss");
		pll_locked = 1'b0;
		ref_locked = 1'b0;
		ref_done = 1'b0;
		idle_cycles(6);
		cal_start = 1'b1;
		idle_cycles(1);
		cal_start = 1'b0;
		for (int i = 0; i < 4; i++) begin
			check_value("cal_busy", 32'd0, 32'(cal_busy));
			idle_cycles(1);
		end
		issue_read(CSR_ADDR_STATUS);
		drain_reads();
		pll_locked = 1'b1;
		idle_cycles(LOCK_FILTER_CYCLES + 12);
		// lock drops partway through stage 1 and the sequencer must abort
		run_calibration('1, 10);
		idle_cycles(4);
		issue_read(CSR_ADDR_STATUS);
		issue_read(CSR_ADDR_FOM);
		issue_read(CSR_ADDR_FAIL_LOC);
		drain_reads();
		pll_locked = 1'b1;
		idle_cycles(LOCK_FILTER_CYCLES + 12);
		ref_locked = 1'b1;
		end_test();

		begin_test("writes ignored");
		for (int i = 0; i < 7; i++) begin
			rng = lcg_next(rng);
			issue_write(mapped_addrs[i], rng);
		end
		// any valid here is flagged by the compare process
		idle_cycles(4);
		for (int i = 0; i < 7; i++) issue_read(mapped_addrs[i]);
		drain_reads();
		end_test();

		$display("summary: %0d ok, %0d with errors, %0d mismatches in all",
			ok_tests, bad_tests, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/phy_csr_pkg.sv
hw/pll_lock_filter.sv
hw/cal_sequencer.sv
hw/phy_csr.sv
hw/phy_status_top.sv
tests/tb_phy_status.sv

// ==== Bender.yml ====
package:
  name: phy_status

sources:
  - files:
      - hw/phy_csr_pkg.sv
      - hw/pll_lock_filter.sv
      - hw/cal_sequencer.sv
      - hw/phy_csr.sv
      - hw/phy_status_top.sv
  - target: test
    files:
      - tests/tb_phy_status.sv
